// ==== filelist.f ====
+incdir+source
source/rv_core_pkg.sv
source/rv_fetch.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_core.sv
test/rv_core_asserts.sv
test/rv_core_tb.sv

// ==== source/rv_alu.sv ====
// ======================================
// ALU with branch condition output
// ======================================
`include "rv_core_defines.svh"

`default_nettype none

module rv_alu import rv_core_pkg::*; (
   input  alu_op_e             op,
   input  logic [`RV_XLEN-1:0] porta,
   input  logic [`RV_XLEN-1:0] portb,
   output logic [`RV_XLEN-1:0] res,
   output logic                cond
);

   logic [4:0] shamt;
   logic       lt_s;
   logic       lt_u;

   assign shamt = portb[4:0];
   assign lt_s  = $signed(porta) < $signed(portb);
   assign lt_u  = porta < portb;

   always_comb begin
      res  = '0;
      cond = 1'b0;
      case (op)
         ALU_ADD:  res = porta + portb;
         ALU_SUB:  res = porta - portb;
         ALU_AND:  res = porta & portb;
         ALU_OR:   res = porta | portb;
         ALU_XOR:  res = porta ^ portb;
         ALU_SLL:  res = porta << shamt;
         ALU_SRL:  res = porta >> shamt;
         ALU_SRA:  res = $signed(porta) >>> shamt;
         ALU_SLT: begin
            res  = {{(`RV_XLEN-1){1'b0}}, lt_s};
            cond = lt_s;
         end
         ALU_SLTU: begin
            res  = {{(`RV_XLEN-1){1'b0}}, lt_u};
            cond = lt_u;
         end
         // Comparisons only drive the condition
         ALU_EQ:   cond = (porta == portb);
         ALU_NE:   cond = (porta != portb);
         ALU_GE:   cond = ~lt_s;
         ALU_GEU:  cond = ~lt_u;
         default:  res = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== source/rv_core.sv ====
// ======================================
// Two-stage RV32I core top level
// ======================================
`include "rv_core_defines.svh"

`default_nettype none

module rv_core import rv_core_pkg::*; (
   input  logic                clk,
   input  logic                rst_n,
   output logic [`RV_XLEN-1:0] code_addr,
   input  logic [`RV_XLEN-1:0] code_rdata,
   input  logic                code_ack,
   output rv_wb_t              trace,
   output logic                illegal
);

   rv_instr_u           instr;
   rv_ctrl_t            ctrl;
   logic [`RV_XLEN-1:0] exe_pc;
   logic                exe_valid;
   logic [`RV_XLEN-1:0] rs1_data;
   logic [`RV_XLEN-1:0] rs2_data;
   logic [`RV_XLEN-1:0] porta;
   logic [`RV_XLEN-1:0] portb;
   logic [`RV_XLEN-1:0] alu_res;
   logic                alu_cond;
   logic [`RV_XLEN-1:0] link_pc;
   logic [`RV_XLEN-1:0] branch_pc;
   logic [`RV_XLEN-1:0] wb_data;
   logic                rf_write;
   logic                redirect;
   logic [`RV_XLEN-1:0] redirect_pc;

   rv_fetch i_rv_fetch (
      .clk         (clk),
      .rst_n       (rst_n),
      .code_ack    (code_ack),
      .code_rdata  (code_rdata),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .code_addr   (code_addr),
      .instr       (instr),
      .exe_pc      (exe_pc),
      .exe_valid   (exe_valid)
   );

   rv_decoder i_rv_decoder (
      .instr (instr),
      .ctrl  (ctrl)
   );

   rv_regfile i_rv_regfile (
      .clk      (clk),
      .rst_n    (rst_n),
      .rs1      (ctrl.rs1),
      .rs2      (ctrl.rs2),
      .rd       (ctrl.rd),
      .rd_data  (wb_data),
      .rd_write (rf_write),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data)
   );

   // ======================================
   // Operand selection and ALU
   // ======================================
   assign porta = (ctrl.porta_sel == PORTA_PC)  ? exe_pc   : rs1_data;
   assign portb = (ctrl.portb_sel == PORTB_IMM) ? ctrl.imm : rs2_data;

   rv_alu i_rv_alu (
      .op    (ctrl.alu_op),
      .porta (porta),
      .portb (portb),
      .res   (alu_res),
      .cond  (alu_cond)
   );

   // ======================================
   // Next PC and write-back
   // ======================================
   assign link_pc   = exe_pc + `RV_XLEN'd4;
   assign branch_pc = exe_pc + ctrl.imm;

   always_comb begin
      case (ctrl.pc_sel)
         PC_BRANCH:  redirect_pc = branch_pc;
         // Jump targets are halfword aligned, bit 0 dropped
         PC_ALU_RES: redirect_pc = {alu_res[`RV_XLEN-1:1], 1'b0};
         default:    redirect_pc = link_pc;
      endcase
   end

   assign redirect = exe_valid & ((ctrl.pc_sel == PC_ALU_RES) |
                                  ((ctrl.pc_sel == PC_BRANCH) & alu_cond));

   assign wb_data  = (ctrl.rf_src_sel == RF_SRC_LINK) ? link_pc : alu_res;
   assign rf_write = exe_valid & ctrl.rf_write;

   always_comb begin
      trace.valid = rf_write;
      trace.rd    = ctrl.rd;
      trace.data  = wb_data;
      trace.pc    = exe_pc;
   end

   assign illegal = exe_valid & ctrl.illegal;

endmodule

`default_nettype wire

// ==== source/rv_core_defines.svh ====
// ======================================
// Widths, register count, reset PC and
// major opcodes of the RV32I core
// ======================================
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

`default_nettype none

// Data path and register file geometry
`define RV_XLEN      32
`define RV_NUM_REGS  32
`define RV_REG_AW    5

// First fetch address out of reset
`define RV_RESET_PC  32'h0000_0000

// Major opcodes, bits 6:0 of the word
`define RV_OPC_OP      7'b0110011
`define RV_OPC_OP_IMM  7'b0010011
`define RV_OPC_LUI     7'b0110111
`define RV_OPC_AUIPC   7'b0010111
`define RV_OPC_BRANCH  7'b1100011
`define RV_OPC_JAL     7'b1101111
`define RV_OPC_JALR    7'b1100111

// ADDI x0,x0,0
`define RV_NOP_INSTR   32'h0000_0013

`default_nettype wire

`endif

// ==== source/rv_core_pkg.sv ====
// ======================================
// Instruction union, decoded control and
// trace record types
// ======================================
`include "rv_core_defines.svh"

`default_nettype none

package rv_core_pkg;

   // ======================================
   // Instruction formats
   // ======================================
   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rv_fmt_r_t;

   typedef struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } rv_fmt_i_t;

   typedef struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
   } rv_fmt_s_t;

   typedef struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
   } rv_fmt_b_t;

   typedef struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } rv_fmt_u_t;

   typedef struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rv_fmt_j_t;

   // One word, six ways to read it
   typedef union packed {
      rv_fmt_r_t r;
      rv_fmt_i_t i;
      rv_fmt_s_t s;
      rv_fmt_b_t b;
      rv_fmt_u_t u;
      rv_fmt_j_t j;
   } rv_instr_u;

   // ======================================
   // Selectors and decoded control
   // ======================================
   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL,
      ALU_SRA, ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE, ALU_GE, ALU_GEU
   } alu_op_e;

   typedef enum logic {PORTA_RS1, PORTA_PC} porta_sel_e;
   typedef enum logic {PORTB_RS2, PORTB_IMM} portb_sel_e;
   typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_ALU_RES} pc_sel_e;
   typedef enum logic {RF_SRC_ALU, RF_SRC_LINK} rf_src_sel_e;

   typedef struct packed {
      alu_op_e                alu_op;
      porta_sel_e             porta_sel;
      portb_sel_e             portb_sel;
      pc_sel_e                pc_sel;
      rf_src_sel_e            rf_src_sel;
      logic                   rf_write;
      logic                   illegal;
      logic [`RV_XLEN-1:0]    imm;
      logic [`RV_REG_AW-1:0]  rs1;
      logic [`RV_REG_AW-1:0]  rs2;
      logic [`RV_REG_AW-1:0]  rd;
   } rv_ctrl_t;

   // Write-back trace record
   typedef struct packed {
      logic                   valid;
      logic [`RV_REG_AW-1:0]  rd;
      logic [`RV_XLEN-1:0]    data;
      logic [`RV_XLEN-1:0]    pc;
   } rv_wb_t;

endpackage

`default_nettype wire

// ==== source/rv_decoder.sv ====
// ======================================
// RV32I decoder to control struct and
// sign-extended immediate
// ======================================
`include "rv_core_defines.svh"

`default_nettype none

module rv_decoder import rv_core_pkg::*; (
   input  rv_instr_u instr,
   output rv_ctrl_t  ctrl
);

   logic [`RV_XLEN-1:0] imm_i;
   logic [`RV_XLEN-1:0] imm_b;
   logic [`RV_XLEN-1:0] imm_u;
   logic [`RV_XLEN-1:0] imm_j;
   logic [9:0]          f7_f3;

   // ======================================
   // Immediate reconstruction
   // ======================================
   assign imm_i = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
   assign imm_b = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                   instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
   assign imm_u = {instr.u.imm_31_12, 12'b0};
   assign imm_j = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                   instr.j.imm_11, instr.j.imm_10_1, 1'b0};

   assign f7_f3 = {instr.r.funct7, instr.r.funct3};

   // ======================================
   // Opcode decode
   // ======================================
   always_comb begin
      ctrl            = '0;
      ctrl.alu_op     = ALU_ADD;
      ctrl.porta_sel  = PORTA_RS1;
      ctrl.portb_sel  = PORTB_RS2;
      ctrl.pc_sel     = PC_PLUS4;
      ctrl.rf_src_sel = RF_SRC_ALU;
      ctrl.rs1        = instr.r.rs1;
      ctrl.rs2        = instr.r.rs2;
      ctrl.rd         = instr.r.rd;

      case (instr.r.opcode)
         `RV_OPC_OP: begin
            ctrl.rf_write = 1'b1;
            case (f7_f3)
               10'b0000000_000: ctrl.alu_op = ALU_ADD;
               10'b0100000_000: ctrl.alu_op = ALU_SUB;
               10'b0000000_001: ctrl.alu_op = ALU_SLL;
               10'b0000000_010: ctrl.alu_op = ALU_SLT;
               10'b0000000_011: ctrl.alu_op = ALU_SLTU;
               10'b0000000_100: ctrl.alu_op = ALU_XOR;
               10'b0000000_101: ctrl.alu_op = ALU_SRL;
               10'b0100000_101: ctrl.alu_op = ALU_SRA;
               10'b0000000_110: ctrl.alu_op = ALU_OR;
               10'b0000000_111: ctrl.alu_op = ALU_AND;
               default: begin
                  ctrl.illegal  = 1'b1;
                  ctrl.rf_write = 1'b0;
               end
            endcase
         end
         `RV_OPC_OP_IMM: begin
            ctrl.portb_sel = PORTB_IMM;
            ctrl.imm       = imm_i;
            ctrl.rf_write  = 1'b1;
            // Shifts carry funct7 in the upper immediate bits
            casez (f7_f3)
               10'b???????_000: ctrl.alu_op = ALU_ADD;
               10'b???????_010: ctrl.alu_op = ALU_SLT;
               10'b???????_011: ctrl.alu_op = ALU_SLTU;
               10'b???????_100: ctrl.alu_op = ALU_XOR;
               10'b???????_110: ctrl.alu_op = ALU_OR;
               10'b???????_111: ctrl.alu_op = ALU_AND;
               10'b0000000_001: ctrl.alu_op = ALU_SLL;
               10'b0000000_101: ctrl.alu_op = ALU_SRL;
               10'b0100000_101: ctrl.alu_op = ALU_SRA;
               default: begin
                  ctrl.illegal  = 1'b1;
                  ctrl.rf_write = 1'b0;
               end
            endcase
         end
         `RV_OPC_LUI: begin
            // rs1 forced to x0 so the adder passes the immediate
            ctrl.rs1       = '0;
            ctrl.portb_sel = PORTB_IMM;
            ctrl.imm       = imm_u;
            ctrl.rf_write  = 1'b1;
         end
         `RV_OPC_AUIPC: begin
            ctrl.porta_sel = PORTA_PC;
            ctrl.portb_sel = PORTB_IMM;
            ctrl.imm       = imm_u;
            ctrl.rf_write  = 1'b1;
         end
         `RV_OPC_JAL: begin
            ctrl.porta_sel  = PORTA_PC;
            ctrl.portb_sel  = PORTB_IMM;
            ctrl.imm        = imm_j;
            ctrl.pc_sel     = PC_ALU_RES;
            ctrl.rf_src_sel = RF_SRC_LINK;
            ctrl.rf_write   = 1'b1;
         end
         `RV_OPC_JALR: begin
            ctrl.portb_sel  = PORTB_IMM;
            ctrl.imm        = imm_i;
            ctrl.pc_sel     = PC_ALU_RES;
            ctrl.rf_src_sel = RF_SRC_LINK;
            ctrl.rf_write   = (instr.i.funct3 == 3'b000);
            ctrl.illegal    = (instr.i.funct3 != 3'b000);
            if (ctrl.illegal) begin
               ctrl.pc_sel = PC_PLUS4;
            end
         end
         `RV_OPC_BRANCH: begin
            ctrl.imm    = imm_b;
            ctrl.pc_sel = PC_BRANCH;
            case (instr.b.funct3)
               3'b000:  ctrl.alu_op = ALU_EQ;
               3'b001:  ctrl.alu_op = ALU_NE;
               3'b100:  ctrl.alu_op = ALU_SLT;
               3'b101:  ctrl.alu_op = ALU_GE;
               3'b110:  ctrl.alu_op = ALU_SLTU;
               3'b111:  ctrl.alu_op = ALU_GEU;
               default: begin
                  ctrl.illegal = 1'b1;
                  ctrl.pc_sel  = PC_PLUS4;
               end
            endcase
         end
         default: begin
            // Loads, stores, fences and system words land here
            ctrl.illegal = 1'b1;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== source/rv_fetch.sv ====
// ======================================
// Fetch PC, flow FSM and instruction
// register feeding the execute stage
// ======================================
`include "rv_core_defines.svh"

`default_nettype none

module rv_fetch import rv_core_pkg::*; (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                code_ack,
   input  logic [`RV_XLEN-1:0] code_rdata,
   input  logic                redirect,
   input  logic [`RV_XLEN-1:0] redirect_pc,
   output logic [`RV_XLEN-1:0] code_addr,
   output rv_instr_u           instr,
   output logic [`RV_XLEN-1:0] exe_pc,
   output logic                exe_valid
);

   typedef enum logic {ST_RUN, ST_FLUSH} flow_state_e;

   flow_state_e         state;
   flow_state_e         state_next;
   logic [`RV_XLEN-1:0] fetch_pc;
   logic [`RV_XLEN-1:0] next_pc;
   logic                accept;

   // ======================================
   // Flow control
   // ======================================
   always_comb begin
      accept     = 1'b0;
      state_next = ST_RUN;
      next_pc    = fetch_pc;
      if (redirect) begin
         // Word in flight is on the old path, drop it
         next_pc = redirect_pc;
      end else begin
         case (state)
            ST_FLUSH: begin
               // Word in flight was requested under reset, re-issue fetch_pc
               state_next = ST_RUN;
            end
            default: begin
               if (code_ack) begin
                  accept  = 1'b1;
                  next_pc = fetch_pc + `RV_XLEN'd4;
               end
            end
         endcase
      end
   end

   assign code_addr = next_pc;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= ST_FLUSH;
         fetch_pc  <= `RV_RESET_PC;
         exe_valid <= 1'b0;
      end else begin
         state     <= state_next;
         fetch_pc  <= next_pc;
         exe_valid <= accept;
      end
   end

   // Instruction register and its PC
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         instr  <= `RV_NOP_INSTR;
         exe_pc <= `RV_RESET_PC;
      end else if (accept) begin
         instr  <= code_rdata;
         exe_pc <= fetch_pc;
      end
   end

endmodule

`default_nettype wire

// ==== source/rv_regfile.sv ====
// ======================================
// Register file, two reads, one write
// ======================================
`include "rv_core_defines.svh"

`default_nettype none

module rv_regfile (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [`RV_REG_AW-1:0] rs1,
   input  logic [`RV_REG_AW-1:0] rs2,
   input  logic [`RV_REG_AW-1:0] rd,
   input  logic [`RV_XLEN-1:0]   rd_data,
   input  logic                  rd_write,
   output logic [`RV_XLEN-1:0]   rs1_data,
   output logic [`RV_XLEN-1:0]   rs2_data
);

   // x0 has no storage
   logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 1; i < `RV_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (rd_write && (rd != '0)) begin
         regs[rd] <= rd_data;
      end
   end

   assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
   assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== test/rv_core_asserts.sv ====
// ========================================
// Port assertions for the core and bind
// ========================================
`include "rv_core_defines.svh"

`default_nettype none

module rv_core_asserts (
   input logic                clk,
   input logic                rst_n,
   input logic [`RV_XLEN-1:0] code_addr,
   input logic                code_ack,
   input logic                redirect,
   input logic                trace_valid,
   input logic                illegal
);

   timeunit 1ns;
   timeprecision 1ps;

   // One strobe per executed word at most
   strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(illegal && trace_valid))
      else $error("illegal and trace.valid high in the same cycle");

   // Fetch address only moves on an accepted word or a redirect
   addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (!code_ack && !redirect) |-> (code_addr == $past(code_addr)))
      else $error("code_addr moved without ack or redirect");

   quiet_after_reset: assert property (@(posedge clk)
      $rose(rst_n) |-> (!illegal && !trace_valid))
      else $error("strobe in the first cycle after reset");

endmodule

bind rv_core rv_core_asserts i_rv_core_asserts (
   .clk         (clk),
   .rst_n       (rst_n),
   .code_addr   (code_addr),
   .code_ack    (code_ack),
   .redirect    (redirect),
   .trace_valid (trace.valid),
   .illegal     (illegal)
);

`default_nettype wire

// ==== test/rv_core_tb.sv ====
// ========================================
// Directed tests for the core with a code
// memory model and an ISA reference model
// ========================================
`include "rv_core_defines.svh"

`default_nettype none

module rv_core_tb import rv_core_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   logic                clk = 1'b0;
   logic                rst_n = 1'b0;
   logic [`RV_XLEN-1:0] code_addr;
   logic [`RV_XLEN-1:0] code_rdata = '0;
   logic                code_ack = 1'b0;
   rv_wb_t              trace;
   logic                illegal;

   logic [31:0] prog [0:63];
   int          prog_len = 0;
   logic        stall_en = 1'b0;
   integer      seed = 8680;
   logic [31:0] rnd;
   rv_wb_t      exp_q [$];
   rv_wb_t      got_q [$];
   int          exp_ill = 0;
   int          ill_cnt = 0;
   int          err_cnt = 0;
   int          test_cnt = 0;
   int          bad_tests = 0;

   rv_core i_rv_core (
      .clk        (clk),
      .rst_n      (rst_n),
      .code_addr  (code_addr),
      .code_rdata (code_rdata),
      .code_ack   (code_ack),
      .trace      (trace),
      .illegal    (illegal)
   );

   always #20 clk = ~clk;

   // ========================================
   // Code memory and trace monitor
   // ========================================
   always @(posedge clk) begin
      rnd = $random(seed);
      if (!rst_n) begin
         code_ack   <= 1'b0;
         code_rdata <= '0;
      end else if (stall_en && rnd[0]) begin
         // Junk word on a stalled cycle
         code_ack   <= 1'b0;
         code_rdata <= 32'hffff_ffff;
      end else begin
         code_ack   <= 1'b1;
         code_rdata <= prog[code_addr[7:2]];
      end
   end

   always @(negedge clk) begin
      if (trace.valid) begin
         got_q.push_back(trace);
      end
      if (illegal) begin
         ill_cnt++;
      end
   end

   // ========================================
   // Instruction encoders
   // ========================================
   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] op_imm(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
      return enc_i(imm, rs1, f3, rd, `RV_OPC_OP_IMM);
   endfunction

   function automatic logic [31:0] op_reg(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
      return {f7, rs2, rs1, f3, rd, `RV_OPC_OP};
   endfunction

   function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] off);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OPC_BRANCH};
   endfunction

   function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OPC_JAL};
   endfunction

   task automatic clear_prog();
      for (int a = 0; a < 64; a++) begin
         // ADDI x0,x0,a so each unused word differs
         prog[a] = op_imm(3'b000, 5'd0, 5'd0, a[11:0]);
      end
      prog_len = 0;
   endtask

   task automatic emit_word(input logic [31:0] w);
      prog[prog_len] = w;
      prog_len++;
   endtask

   // ========================================
   // ISA reference model
   // ========================================
   function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
      case (f3)
         3'b000:  return alt ? a - b : a + b;
         3'b001:  return a << b[4:0];
         3'b010:  return {31'b0, $signed(a) < $signed(b)};
         3'b011:  return {31'b0, a < b};
         3'b100:  return a ^ b;
         3'b101: begin
            if (alt) begin
               return $signed(a) >>> b[4:0];
            end
            return a >> b[4:0];
         end
         3'b110:  return a | b;
         default: return a & b;
      endcase
   endfunction

   task automatic predict_trace();
      logic [31:0] xr [0:31];
      logic [31:0] pc;
      logic [31:0] w;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm_i;
      logic [31:0] imm_b;
      logic [31:0] imm_j;
      logic [31:0] res;
      logic [31:0] nxt;
      logic        wr;
      logic        take;
      rv_wb_t      rec;
      exp_q.delete();
      exp_ill = 0;
      for (int r = 0; r < 32; r++) begin
         xr[r] = '0;
      end
      pc = `RV_RESET_PC;
      for (int step = 0; step < 500; step++) begin
         w     = prog[pc[7:2]];
         a     = xr[w[19:15]];
         b     = xr[w[24:20]];
         imm_i = {{20{w[31]}}, w[31:20]};
         imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
         imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
         nxt   = pc + 32'd4;
         wr    = 1'b1;
         take  = 1'b0;
         res   = '0;
         case (w[6:0])
            `RV_OPC_OP_IMM: res = alu_ref(w[14:12], (w[14:12] == 3'b101) && w[30], a, imm_i);
            `RV_OPC_OP:     res = alu_ref(w[14:12], w[30], a, b);
            `RV_OPC_LUI:    res = {w[31:12], 12'b0};
            `RV_OPC_AUIPC:  res = pc + {w[31:12], 12'b0};
            `RV_OPC_JAL: begin
               res = pc + 32'd4;
               nxt = pc + imm_j;
            end
            `RV_OPC_JALR: begin
               res = pc + 32'd4;
               nxt = (a + imm_i) & ~32'd1;
            end
            `RV_OPC_BRANCH: begin
               wr = 1'b0;
               case (w[14:12])
                  3'b000:  take = (a == b);
                  3'b001:  take = (a != b);
                  3'b100:  take = $signed(a) < $signed(b);
                  3'b101:  take = $signed(a) >= $signed(b);
                  3'b110:  take = a < b;
                  3'b111:  take = a >= b;
                  default: exp_ill++;
               endcase
               if (take) begin
                  nxt = pc + imm_b;
               end
            end
            default: begin
               wr = 1'b0;
               exp_ill++;
            end
         endcase
         if (wr) begin
            rec.valid = 1'b1;
            rec.rd    = w[11:7];
            rec.data  = res;
            rec.pc    = pc;
            exp_q.push_back(rec);
            if (w[11:7] != 5'd0) begin
               xr[w[11:7]] = res;
            end
         end
         // A jump to itself ends the program
         if (nxt == pc) begin
            break;
         end
         pc = nxt;
      end
   endtask

   // ========================================
   // Run and check helpers
   // ========================================
   task automatic apply_reset();
      @(posedge clk);
      rst_n <= 1'b0;
      repeat (5) @(posedge clk);
      got_q.delete();
      ill_cnt = 0;
      rst_n <= 1'b1;
   endtask

   task automatic report_test(input string name, input int errs_before);
      test_cnt++;
      if (err_cnt != errs_before) begin
         bad_tests++;
         $display("%-20s %0d errors", name, err_cnt - errs_before);
      end else begin
         $display("%-20s passed", name);
      end
   endtask

   task automatic run_program(input string name, input logic stall);
      int errs_before;
      int n;
      errs_before = err_cnt;
      predict_trace();
      stall_en = stall;
      apply_reset();
      n = 0;
      while ((got_q.size() < exp_q.size()) && (n < 4000)) begin
         @(negedge clk);
         n++;
      end
      if (got_q.size() < exp_q.size()) begin
         $display("%s: timed out with %0d of %0d trace records", name,
                  got_q.size(), exp_q.size());
         err_cnt++;
      end else begin
         for (int i = 0; i < exp_q.size(); i++) begin
            if (got_q[i].pc !== exp_q[i].pc) begin
               $display("FAIL trace.pc rec %0d: exp %h got %h", i, exp_q[i].pc, got_q[i].pc);
               err_cnt++;
            end
            if (got_q[i].rd !== exp_q[i].rd) begin
               $display("FAIL trace.rd rec %0d: exp %h got %h", i, exp_q[i].rd, got_q[i].rd);
               err_cnt++;
            end
            if (got_q[i].data !== exp_q[i].data) begin
               $display("FAIL trace.data rec %0d: exp %h got %h", i,
                        exp_q[i].data, got_q[i].data);
               err_cnt++;
            end
         end
         if (ill_cnt != exp_ill) begin
            $display("FAIL illegal count: exp %h got %h", exp_ill, ill_cnt);
            err_cnt++;
         end
      end
      report_test(name, errs_before);
   endtask

   // ========================================
   // Tests
   // ========================================
   task automatic reset_state();
      int errs_before;
      int n;
      errs_before = err_cnt;
      stall_en = 1'b0;
      clear_prog();
      apply_reset();
      n = 0;
      do begin
         @(negedge clk);
         // Once a word arrives the core already requests the next one
         if (!code_ack && (code_addr !== `RV_RESET_PC)) begin
            $display("FAIL code_addr: exp %h got %h", `RV_RESET_PC, code_addr);
            err_cnt++;
         end
         if (trace.valid || illegal) begin
            $display("Strobe seen before the first code ack");
            err_cnt++;
         end
         n++;
      end while (!code_ack && (n < 20));
      if (!code_ack) begin
         $display("No code ack arrived after reset");
         err_cnt++;
      end
      report_test("reset_state", errs_before);
   endtask

   task automatic imm_ops();
      clear_prog();
      emit_word(op_imm(3'b000, 5'd1, 5'd0, 12'hffb));
      emit_word(op_imm(3'b111, 5'd2, 5'd1, 12'h0f0));
      emit_word(op_imm(3'b110, 5'd3, 5'd1, 12'h123));
      emit_word(op_imm(3'b100, 5'd4, 5'd1, 12'hfff));
      emit_word(op_imm(3'b010, 5'd5, 5'd1, 12'hffc));
      emit_word(op_imm(3'b011, 5'd6, 5'd1, 12'hffc));
      emit_word(op_imm(3'b001, 5'd7, 5'd1, 12'h003));
      emit_word(op_imm(3'b101, 5'd8, 5'd1, 12'h004));
      emit_word(op_imm(3'b101, 5'd9, 5'd1, 12'h404));
      // x0 write is traced but x0 keeps reading zero
      emit_word(op_imm(3'b000, 5'd0, 5'd1, 12'h007));
      emit_word(op_imm(3'b000, 5'd10, 5'd0, 12'h001));
      emit_word(enc_j(21'd0, 5'd0));
      run_program("imm_ops", 1'b0);
   endtask

   task automatic reg_ops();
      clear_prog();
      emit_word(op_imm(3'b000, 5'd1, 5'd0, 12'd100));
      emit_word(op_imm(3'b000, 5'd2, 5'd0, 12'hff9));
      emit_word(op_reg(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
      emit_word(op_reg(7'h20, 3'b000, 5'd4, 5'd2, 5'd1));
      emit_word(op_reg(7'h00, 3'b111, 5'd5, 5'd3, 5'd2));
      emit_word(op_reg(7'h00, 3'b110, 5'd6, 5'd1, 5'd2));
      emit_word(op_reg(7'h00, 3'b100, 5'd7, 5'd4, 5'd1));
      emit_word(op_reg(7'h00, 3'b001, 5'd8, 5'd2, 5'd1));
      emit_word(op_reg(7'h00, 3'b101, 5'd9, 5'd2, 5'd1));
      emit_word(op_reg(7'h20, 3'b101, 5'd10, 5'd2, 5'd1));
      emit_word(op_reg(7'h00, 3'b010, 5'd11, 5'd2, 5'd1));
      emit_word(op_reg(7'h00, 3'b011, 5'd12, 5'd2, 5'd1));
      emit_word({20'habcde, 5'd13, `RV_OPC_LUI});
      emit_word({20'h00012, 5'd14, `RV_OPC_AUIPC});
      emit_word(enc_j(21'd0, 5'd0));
      run_program("reg_ops", 1'b0);
   endtask

   task automatic branch_ops();
      logic [2:0] f3s [0:5];
      logic [4:0] ta [0:5];
      logic [4:0] tb [0:5];
      logic [4:0] na [0:5];
      logic [4:0] nb [0:5];
      f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
      // Operands x1 = -1 and x2 = 2 in taken and fall-through pairs
      ta  = '{5'd1, 5'd1, 5'd1, 5'd2, 5'd2, 5'd1};
      tb  = '{5'd1, 5'd2, 5'd2, 5'd1, 5'd1, 5'd2};
      na  = '{5'd1, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2};
      nb  = '{5'd2, 5'd1, 5'd1, 5'd2, 5'd2, 5'd1};
      clear_prog();
      emit_word(op_imm(3'b000, 5'd1, 5'd0, 12'hfff));
      emit_word(op_imm(3'b000, 5'd2, 5'd0, 12'h002));
      for (int k = 0; k < 6; k++) begin
         emit_word(enc_b(f3s[k], ta[k], tb[k], 13'd8));
         emit_word(op_imm(3'b000, 5'd3, 5'd0, 12'(k + 1)));
         emit_word(op_imm(3'b000, 5'd4, 5'd0, 12'(k + 1)));
         emit_word(enc_b(f3s[k], na[k], nb[k], 13'd8));
         emit_word(op_imm(3'b000, 5'd3, 5'd0, 12'(k + 16)));
         emit_word(op_imm(3'b000, 5'd4, 5'd0, 12'(k + 16)));
      end
      // Backward branch loop of three turns
      emit_word(op_imm(3'b000, 5'd5, 5'd0, 12'd3));
      emit_word(op_imm(3'b000, 5'd5, 5'd5, 12'hfff));
      emit_word(enc_b(3'b001, 5'd5, 5'd0, 13'h1ffc));
      emit_word(enc_j(21'd0, 5'd0));
      run_program("branches", 1'b0);
   endtask

   task automatic jump_ops();
      clear_prog();
      emit_word(enc_j(21'd12, 5'd1));
      emit_word(op_imm(3'b000, 5'd5, 5'd0, 12'd11));
      emit_word(enc_j(21'd16, 5'd0));
      emit_word(enc_i(12'd4, 5'd1, 3'b000, 5'd7, `RV_OPC_JALR));
      emit_word(op_imm(3'b000, 5'd5, 5'd0, 12'd22));
      emit_word(op_imm(3'b000, 5'd5, 5'd0, 12'd33));
      // Odd JALR target loses bit 0
      emit_word(op_imm(3'b000, 5'd9, 5'd0, 12'd37));
      emit_word(enc_i(12'd0, 5'd9, 3'b000, 5'd10, `RV_OPC_JALR));
      emit_word(op_imm(3'b000, 5'd5, 5'd0, 12'd44));
      emit_word(enc_j(21'd0, 5'd0));
      run_program("jumps", 1'b0);
   endtask

   task automatic stall_illegal();
      clear_prog();
      emit_word(op_imm(3'b000, 5'd1, 5'd0, 12'd5));
      // LW x2,0(x1) is unsupported
      emit_word(enc_i(12'd0, 5'd1, 3'b010, 5'd2, 7'b0000011));
      emit_word(op_imm(3'b000, 5'd2, 5'd1, 12'd3));
      emit_word(enc_b(3'b001, 5'd1, 5'd2, 13'd8));
      emit_word(op_imm(3'b000, 5'd3, 5'd0, 12'd1));
      emit_word(enc_j(21'd8, 5'd4));
      emit_word(op_imm(3'b000, 5'd3, 5'd0, 12'd2));
      emit_word(op_reg(7'h20, 3'b000, 5'd5, 5'd2, 5'd1));
      emit_word(op_reg(7'h00, 3'b001, 5'd6, 5'd2, 5'd1));
      emit_word(enc_j(21'd0, 5'd0));
      run_program("illegal_no_stall", 1'b0);
      run_program("illegal_stalled", 1'b1);
   endtask

   initial begin
      reset_state();
      imm_ops();
      reg_ops();
      branch_ops();
      jump_ops();
      stall_illegal();
      $display("Tests %0d, failed tests %0d, failed checks %0d", test_cnt, bad_tests, err_cnt);
      if (err_cnt == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
